/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int pc_width = 10;

	// opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_addi  = 6'h01;
	localparam logic [5:0] op_ori   = 6'h02;
	localparam logic [5:0] op_lw    = 6'h03;
	localparam logic [5:0] op_sw    = 6'h04;
	localparam logic [5:0] op_beq   = 6'h05;
	localparam logic [5:0] op_bne   = 6'h06;

	// r-type function codes
	localparam logic [4:0] fn_add = 5'h00;
	localparam logic [4:0] fn_sub = 5'h01;
	localparam logic [4:0] fn_and = 5'h02;
	localparam logic [4:0] fn_or  = 5'h03;
	localparam logic [4:0] fn_xor = 5'h04;
	localparam logic [4:0] fn_slt = 5'h05;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [5:0] spare;
		logic [4:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [15:0] imm;
	} i_fmt_t;

	// same word, two field layouts
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_t;

	typedef enum logic {
		src2_rb  = 1'b0,
		src2_imm = 1'b1
	} src2_sel_t;

	typedef enum logic {
		wb_alu  = 1'b0,
		wb_load = 1'b1
	} wb_sel_t;

	typedef struct packed {
		alu_op_t   alu_op;
		src2_sel_t src2_sel;
		wb_sel_t   wb_sel;
		logic      imm_zero_ext;
		logic      reg_write;
	} ctrl_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
	} apb_rsp_t;

endpackage

`default_nettype wire

/* logic/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  logic                enable_memaccess,
	input  logic                reset,
	input  core_pkg::instr_t    imem_rdata,
	input  logic                alu_zero,
	input  logic [31:0]         alu_result,
	input  logic [31:0]         rt_data,
	input  core_pkg::apb_rsp_t  apb_in,
	output core_pkg::ctrl_t     ctrl,
	output logic [4:0]          ra_addr,
	output logic [4:0]          rb_addr,
	output logic [4:0]          rt_addr,
	output logic [15:0]         ir_imm,
	output logic                phase_decode,
	output logic                phase_execute,
	output logic                phase_writeback,
	output logic                take_branch,
	output logic                is_branch,
	output logic                ovf_update,
	output logic [31:0]         load_data,
	output core_pkg::apb_req_t  apb
);
	import core_pkg::*;

	typedef enum logic [2:0] {
		s_fetch,
		s_decode,
		s_execute,
		s_setup,
		s_access,
		s_writeback
	} state_t;

	state_t      state;
	state_t      state_next;
	instr_t      ir;
	instr_t      instr;
	logic [5:0]  opcode;
	logic [31:0] addr_q;
	logic        is_mem;
	logic        is_store;
	logic        xfer_done;

	// imem word shows up during decode, ir holds it after that
	assign instr  = (state == s_decode) ? imem_rdata : ir;
	assign opcode = instr.r.opcode;

	assign is_branch = (opcode == op_beq) || (opcode == op_bne);
	assign is_store  = (opcode == op_sw);
	assign is_mem    = (opcode == op_lw) || is_store;

	// flag follows add, sub and addi only
	assign ovf_update = (opcode == op_addi) ||
		((opcode == op_rtype) && ((instr.r.funct == fn_add) || (instr.r.funct == fn_sub)));

	always_comb begin
		ctrl.alu_op       = alu_add;
		ctrl.src2_sel     = src2_imm;
		ctrl.wb_sel       = wb_alu;
		ctrl.imm_zero_ext = 1'b0;
		ctrl.reg_write    = 1'b0;
		ra_addr = instr.i.ra;
		rt_addr = instr.i.rt;
		rb_addr = 5'd0;
		ir_imm  = instr.i.imm;
		case (opcode)
			op_rtype: begin
				rb_addr = instr.r.rb;
				ir_imm  = 16'd0;
				ctrl.src2_sel  = src2_rb;
				ctrl.reg_write = 1'b1;
				case (instr.r.funct)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_or:  ctrl.alu_op = alu_or;
					fn_xor: ctrl.alu_op = alu_xor;
					fn_slt: ctrl.alu_op = alu_slt;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: ctrl.reg_write = 1'b1;
			op_ori: begin
				ctrl.alu_op       = alu_or;
				ctrl.imm_zero_ext = 1'b1;
				ctrl.reg_write    = 1'b1;
			end
			op_lw: begin
				ctrl.wb_sel    = wb_load;
				ctrl.reg_write = 1'b1;
			end
			// compare ra with rt, zero flag decides
			op_beq, op_bne: ctrl.alu_op = alu_sub;
			default: ;
		endcase
	end

	assign xfer_done = (state == s_access) && apb_in.pready;

	always_comb begin
		state_next = state;
		case (state)
			s_fetch:     state_next = s_decode;
			s_decode:    state_next = s_execute;
			s_execute:   state_next = is_mem ? s_setup : s_writeback;
			s_setup:     state_next = s_access;
			s_access:    state_next = xfer_done ? s_writeback : s_access;
			s_writeback: state_next = s_fetch;
			default:     state_next = s_fetch;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			state       <= s_fetch;
			ir          <= '0;
			take_branch <= 1'b0;
		end else begin
			state <= state_next;
			if (state == s_decode)
				ir <= imem_rdata;
			if (state == s_execute)
				take_branch <= ((opcode == op_beq) && alu_zero) ||
					((opcode == op_bne) && !alu_zero);
		end
	end

	always_ff @(posedge enable_memaccess) begin
		if (phase_execute)
			addr_q <= alu_result;
		if (xfer_done && !is_store)
			load_data <= apb_in.prdata;
	end

	assign phase_decode    = (state == s_decode);
	assign phase_execute   = (state == s_execute);
	assign phase_writeback = (state == s_writeback);

	// apb master, setup then access until pready
	assign apb.psel    = (state == s_setup) || (state == s_access);
	assign apb.penable = (state == s_access);
	assign apb.pwrite  = is_store;
	assign apb.paddr   = addr_q[11:0];
	assign apb.pwdata  = rt_data;

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic        enable_memaccess,
	input  logic        reset,
	input  logic        phase_decode,
	input  logic        phase_writeback,
	input  logic        reg_write,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	input  logic [4:0]  rt_addr,
	input  logic [31:0] wb_data,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	output logic [31:0] rt_data
);
	logic [31:0] regs [32];

	// r0 is never written so it stays zero
	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (phase_writeback && reg_write && (rt_addr != 5'd0)) begin
			regs[rt_addr] <= wb_data;
		end
	end

	// operands held from decode to writeback
	always_ff @(posedge enable_memaccess) begin
		if (phase_decode) begin
			ra_data <= regs[ra_addr];
			rb_data <= regs[rb_addr];
			rt_data <= regs[rt_addr];
		end
	end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic               enable_memaccess,
	input  logic               reset,
	input  logic               phase_execute,
	input  logic               ovf_update,
	input  core_pkg::alu_op_t  alu_op,
	input  logic [31:0]        src1,
	input  logic [31:0]        src2,
	output logic [31:0]        alu_result,
	output logic               alu_zero,
	output logic               alu_overflow
);
	import core_pkg::*;

	logic [31:0] sum;
	logic [31:0] diff;
	logic        ovf_add;
	logic        ovf_sub;
	logic        ovf_next;

	assign sum  = src1 + src2;
	assign diff = src1 - src2;

	// signed overflow from the sign bits
	assign ovf_add = (src1[31] == src2[31]) && (sum[31] != src1[31]);
	assign ovf_sub = (src1[31] != src2[31]) && (diff[31] != src1[31]);

	always_comb begin
		alu_result = sum;
		ovf_next   = 1'b0;
		case (alu_op)
			alu_add: begin
				alu_result = sum;
				ovf_next   = ovf_add;
			end
			alu_sub: begin
				alu_result = diff;
				ovf_next   = ovf_sub;
			end
			alu_and: alu_result = src1 & src2;
			alu_or:  alu_result = src1 | src2;
			alu_xor: alu_result = src1 ^ src2;
			alu_slt: alu_result = {31'd0, $signed(src1) < $signed(src2)};
			default: alu_result = sum;
		endcase
	end

	assign alu_zero = (alu_result == 32'd0);

	always_ff @(posedge enable_memaccess) begin
		if (reset)
			alu_overflow <= 1'b0;
		else if (phase_execute && ovf_update)
			alu_overflow <= ovf_next;
	end

endmodule

`default_nettype wire

/* logic/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select (
	input  core_pkg::ctrl_t ctrl,
	input  logic            is_branch,
	input  logic [15:0]     ir_imm,
	input  logic [31:0]     rb_data,
	input  logic [31:0]     rt_data,
	input  logic [31:0]     alu_result,
	input  logic [31:0]     load_data,
	output logic [31:0]     src2,
	output logic [31:0]     wb_data
);
	import core_pkg::*;

	logic [31:0] imm_ext;

	// ori wants zero extension, the rest sign
	assign imm_ext = ctrl.imm_zero_ext ? {16'd0, ir_imm} : {{16{ir_imm[15]}}, ir_imm};

	always_comb begin
		if (is_branch)
			// branches compare ra against rt
			src2 = rt_data;
		else if (ctrl.src2_sel == src2_imm)
			src2 = imm_ext;
		else
			src2 = rb_data;
	end

	always_comb begin
		case (ctrl.wb_sel)
			wb_load: wb_data = load_data;
			default: wb_data = alu_result;
		endcase
	end

endmodule

`default_nettype wire

/* logic/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input  logic                          enable_memaccess,
	input  logic                          reset,
	input  logic                          phase_writeback,
	input  logic                          take_branch,
	input  logic [15:0]                   ir_imm,
	output logic [core_pkg::pc_width-1:0] pc
);
	import core_pkg::*;

	logic [pc_width-1:0] seq_pc;
	logic [pc_width-1:0] br_pc;

	assign seq_pc = pc + pc_width'(1);
	// offset counts words from pc+1, wraps in the pc width
	assign br_pc  = seq_pc + ir_imm[pc_width-1:0];

	always_ff @(posedge enable_memaccess) begin
		if (reset)
			pc <= '0;
		else if (phase_writeback)
			pc <= take_branch ? br_pc : seq_pc;
	end

endmodule

`default_nettype wire

/* logic/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic                          enable_memaccess,
	input  logic                          reset,
	input  core_pkg::instr_t              imem_rdata,
	input  core_pkg::apb_rsp_t            apb_in,
	output logic [core_pkg::pc_width-1:0] imem_addr,
	output core_pkg::apb_req_t            apb,
	output logic                          alu_overflow
);
	import core_pkg::*;

	ctrl_t       ctrl;
	logic [4:0]  ra_addr;
	logic [4:0]  rb_addr;
	logic [4:0]  rt_addr;
	logic [15:0] ir_imm;
	logic        phase_decode;
	logic        phase_execute;
	logic        phase_writeback;
	logic        take_branch;
	logic        is_branch;
	logic        ovf_update;
	logic [31:0] load_data;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] rt_data;
	logic [31:0] src2;
	logic [31:0] wb_data;
	logic [31:0] alu_result;
	logic        alu_zero;

	controller controller_i (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.imem_rdata(imem_rdata),
		.alu_zero(alu_zero),
		.alu_result(alu_result),
		.rt_data(rt_data),
		.apb_in(apb_in),
		.ctrl(ctrl),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ir_imm(ir_imm),
		.phase_decode(phase_decode),
		.phase_execute(phase_execute),
		.phase_writeback(phase_writeback),
		.take_branch(take_branch),
		.is_branch(is_branch),
		.ovf_update(ovf_update),
		.load_data(load_data),
		.apb(apb)
	);

	regfile regfile_i (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.phase_decode(phase_decode),
		.phase_writeback(phase_writeback),
		.reg_write(ctrl.reg_write),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.wb_data(wb_data),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	alu alu_i (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.phase_execute(phase_execute),
		.ovf_update(ovf_update),
		.alu_op(ctrl.alu_op),
		.src1(ra_data),
		.src2(src2),
		.alu_result(alu_result),
		.alu_zero(alu_zero),
		.alu_overflow(alu_overflow)
	);

	operand_select operand_select_i (
		.ctrl(ctrl),
		.is_branch(is_branch),
		.ir_imm(ir_imm),
		.rb_data(rb_data),
		.rt_data(rt_data),
		.alu_result(alu_result),
		.load_data(load_data),
		.src2(src2),
		.wb_data(wb_data)
	);

	pc_unit pc_unit_i (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.phase_writeback(phase_writeback),
		.take_branch(take_branch),
		.ir_imm(ir_imm),
		.pc(imem_addr)
	);

endmodule

`default_nettype wire

/* tests/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam int data_words = 128;
	localparam int mem_words  = 1024;

	logic                enable_memaccess = 1'b0;
	logic                reset;
	instr_t              imem_rdata;
	apb_rsp_t            apb_in;
	logic [pc_width-1:0] imem_addr;
	apb_req_t            apb;
	logic                alu_overflow;

	logic [31:0]         testdata [data_words];
	logic [31:0]         imem [1 << pc_width];
	logic [31:0]         dmem [mem_words];
	logic [pc_width-1:0] fetch_addr;
	apb_req_t            setup_req;
	integer              seed;
	int                  wait_left;
	int                  prog_len;
	int                  n_stores;
	int                  n_tests;
	int                  rec_base;
	int                  cnt_base;
	int                  store_idx;
	int                  test_idx;
	int                  test_left;
	int                  test_err_base;
	int                  tests_failed;
	int                  errors;

	core_top dut_i (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.imem_rdata(imem_rdata),
		.apb_in(apb_in),
		.imem_addr(imem_addr),
		.apb(apb),
		.alu_overflow(alu_overflow)
	);

	always #5 enable_memaccess = ~enable_memaccess;

	task automatic check_reset_state(input string when);
		if (apb.psel !== 1'b0 || apb.penable !== 1'b0 || imem_addr !== '0 ||
			alu_overflow !== 1'b0) begin
			$display("error %0t: %s, psel %b penable %b imem_addr %0d alu_overflow %b",
				$time, when, apb.psel, apb.penable, imem_addr, alu_overflow);
			errors++;
		end
	endtask

	task automatic check_store(input apb_req_t req, input logic [31:0] exp_addr,
		input logic [31:0] exp_data);
		if (req.paddr !== exp_addr[11:0] || req.pwdata !== exp_data) begin
			$display("error %0t: store %0d wrote 0x%08h to 0x%03h, expected 0x%08h to 0x%03h",
				$time, store_idx, req.pwdata, req.paddr, exp_data, exp_addr[11:0]);
			errors++;
		end
	endtask

	task automatic check_overflow(input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %0t: alu_overflow %b at store %0d, expected %b",
				$time, got, store_idx, exp);
			errors++;
		end
	endtask

	// request must not move while the slave stalls
	task automatic check_held(input apb_req_t now, input apb_req_t held);
		if (now.paddr !== held.paddr || now.pwrite !== held.pwrite ||
			now.pwdata !== held.pwdata) begin
			$display("error %0t: apb request changed to 0x%03h/%b/0x%08h from 0x%03h/%b/0x%08h",
				$time, now.paddr, now.pwrite, now.pwdata, held.paddr, held.pwrite, held.pwdata);
			errors++;
		end
	endtask

	task automatic close_test(input string name);
		int test_errors;
		test_errors = errors - test_err_base;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s done: %0d errors", name, test_errors);
		test_err_base = errors;
	endtask

	task automatic take_store();
		int base;
		if (store_idx >= n_stores) begin
			$display("error %0t: unexpected write of 0x%08h to 0x%03h",
				$time, apb.pwdata, apb.paddr);
			errors++;
		end else begin
			base = rec_base + 3 * store_idx;
			check_store(apb, testdata[base], testdata[base + 1]);
			check_overflow(alu_overflow, testdata[base + 2][0]);
			store_idx++;
			test_left--;
			if (test_left == 0) begin
				close_test($sformatf("%0d", test_idx + 1));
				test_idx++;
				if (test_idx < n_tests)
					test_left = testdata[cnt_base + test_idx];
			end
		end
	endtask

	// apb slave, 0 to 3 wait states per transfer
	task automatic serve_apb();
		if (!apb.psel) begin
			apb_in.pready = 1'b0;
		end else if (!apb.penable) begin
			setup_req = apb;
			wait_left = $random(seed) & 3;
			apb_in.pready = 1'b0;
		end else begin
			check_held(apb, setup_req);
			if (wait_left > 0) begin
				wait_left--;
				apb_in.pready = 1'b0;
			end else begin
				apb_in.pready = 1'b1;
				if (apb.pwrite) begin
					dmem[apb.paddr[11:2]] = apb.pwdata;
					take_store();
				end else begin
					apb_in.prdata = dmem[apb.paddr[11:2]];
				end
			end
		end
	endtask

	initial begin : bus_models
		imem_rdata = '0;
		apb_in = '0;
		fetch_addr = '0;
		wait_left = 0;
		seed = 32'hca47;
		for (int i = 0; i < mem_words; i++)
			dmem[i] = {10'(i), 12'h000, 10'(i)};
		forever begin
			@(posedge enable_memaccess);
			#1;
			// word for the address seen one cycle back
			imem_rdata = imem[fetch_addr];
			fetch_addr = imem_addr;
			serve_apb();
		end
	end

	initial begin
		reset = 1'b1;
		errors = 0;
		tests_failed = 0;
		store_idx = 0;
		test_idx = 0;
		test_err_base = 0;
		$readmemh("tests/core_testdata.mem", testdata);
		prog_len = testdata[0];
		n_stores = testdata[1];
		n_tests = testdata[2];
		rec_base = 3 + prog_len;
		cnt_base = rec_base + 3 * n_stores;
		test_left = testdata[cnt_base];
		for (int i = 0; i < (1 << pc_width); i++)
			imem[i] = '0;
		for (int i = 0; i < prog_len; i++)
			imem[i] = testdata[3 + i];

		@(posedge enable_memaccess);
		#1;
		check_reset_state("during reset");
		@(posedge enable_memaccess);
		#1;
		reset = 1'b0;
		@(posedge enable_memaccess);
		#1;
		check_reset_state("after reset");
		close_test("0 (reset)");

		wait (store_idx == n_stores);
		wait (int'(imem_addr) == prog_len - 1);
		// two turns of the closing self-loop
		repeat (8) @(posedge enable_memaccess);

		$display("summary: %0d tests, %0d failed, %0d of %0d stores seen, %0d errors",
			n_tests + 1, tests_failed, store_idx, n_stores, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		int limit_ns;
		#1;
		// each word four times at the slowest instruction
		limit_ns = prog_len * 4 * (6 + 3) * 10;
		#(limit_ns);
		$display("timed out waiting for stores after %0d ns, %0d of %0d seen",
			limit_ns, store_idx, n_stores);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/core_testdata.mem */
// header: program words, store records, tests; then the program,
// store records (paddr pwdata overflow) and the store count of each test
0000002d 00000012 00000005
// test 1: r-type ops, each result stored
04200064 0440001e           // addi r1,r0,100 ; addi r2,r0,30
00611000 10600100           // add r3,r1,r2 ; sw r3,0x100(r0)
00820801 10800104           // sub r4,r2,r1 ; sw r4,0x104(r0)
00a11002 10a00108           // and r5,r1,r2 ; sw r5,0x108(r0)
00a11003 10a0010c           // or r5,r1,r2 ; sw r5,0x10c(r0)
00a11004 10a00110           // xor r5,r1,r2 ; sw r5,0x110(r0)
00a40805 10a00114           // slt r5,r4,r1 ; sw r5,0x114(r0)
00a12005 10a00118           // slt r5,r1,r4 ; sw r5,0x118(r0)
// test 2: immediates
04c0fff0 10c00120           // addi r6,r0,-16 ; sw r6,0x120(r0)
08e08001 10e00124           // ori r7,r0,0x8001 ; sw r7,0x124(r0)
05068000 11000128           // addi r8,r6,-32768 ; sw r8,0x128(r0)
// test 3: loads of stored words
0d200104 11200200           // lw r9,0x104(r0) ; sw r9,0x200(r0)
0d400124 11400204           // lw r10,0x124(r0) ; sw r10,0x204(r0)
01695000 11600208           // add r11,r9,r10 ; sw r11,0x208(r0)
// test 4: branches, the stores to 0x3f0 and 0x3f4 are skipped
14410001 10200300           // beq r1,r2,+1 not taken ; sw r1,0x300(r0)
18410001 104003f0           // bne r1,r2,+1 taken ; sw r2,0x3f0(r0)
05810000                    // addi r12,r1,0
15810001 104003f4           // beq r1,r12,+1 taken ; sw r2,0x3f4(r0)
19810001 11800304           // bne r1,r12,+1 not taken ; sw r12,0x304(r0)
// test 5: overflow flag, 0x7fc holds fill word 0x7fc001ff
0da007fc 01cd6800           // lw r13,0x7fc(r0) ; add r14,r13,r13 overflows
09e00001 11c00308 11e0030c  // ori r15,r0,1 ; sw r14,0x308(r0) ; sw r15,0x30c(r0)
06000005 12000310           // addi r16,r0,5 ; sw r16,0x310(r0)
1400ffff                    // beq r0,r0,-1 self-loop
// store records
00000100 00000082 0
00000104 ffffffba 0
00000108 00000004 0
0000010c 0000007e 0
00000110 0000007a 0
00000114 00000001 0
00000118 00000000 0
00000120 fffffff0 0
00000124 00008001 0
00000128 ffff7ff0 0
00000200 ffffffba 0
00000204 00008001 0
00000208 00007fbb 0
00000300 00000064 0
00000304 00000064 0
00000308 ff8003fe 1
0000030c 00000001 1
00000310 00000005 0
// stores per test
00000007 00000003 00000003 00000002 00000003

/* compile.f */
logic/core_pkg.sv
logic/controller.sv
logic/regfile.sv
logic/alu.sv
logic/operand_select.sv
logic/pc_unit.sv
logic/core_top.sv
tests/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module core_tb -f compile.f \
	--Mdir obj_dir -o core_tb

./obj_dir/core_tb | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "run.sh: simulation passed"
else
	echo "run.sh: simulation failed"
	exit 1
fi
